/* xbar_pkg.sv */
package xbar_pkg;

    localparam int NUM_CH   = 3;
    localparam int NUM_BANK = 4;
    localparam int BANK_LSB = 6;    // 64-byte lines.
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 128;
    localparam int ROB_MAX  = 16;
    localparam int WBUF_MAX = 16;

    typedef logic [1:0]                  ch_id_t;
    typedef logic [1:0]                  bank_id_t;
    typedef logic [$clog2(ROB_MAX)-1:0]  rob_id_t;
    typedef logic [$clog2(WBUF_MAX)-1:0] wbuf_id_t;
    typedef logic [1:0]                  crdt_t;    // Up to NUM_CH returns per cycle.

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } ch_req_t;

    // The write data goes to the bank through its write buffer.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        ch_id_t            ch_id;
        rob_id_t           rob_id;
        wbuf_id_t          wbuf_id;
    } bank_req_t;

    typedef struct packed {
        wbuf_id_t          wbuf_id;
        logic [DATA_W-1:0] wdata;
    } wbuf_wr_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        ch_id_t            ch_id;
        rob_id_t           rob_id;
    } bank_rsp_t;

endpackage

/* req_xbar.sv */
`timescale 1ns/10ps

module req_xbar
    import xbar_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_CH-1:0]   ch_req_valid,
    input  ch_req_t             ch_req [NUM_CH],
    output logic [NUM_CH-1:0]   ch_req_ready,
    input  logic [NUM_CH-1:0]   rob_full,
    input  rob_id_t             rob_next_id [NUM_CH],
    output logic [NUM_BANK-1:0] issue_valid,
    output bank_req_t           issue_req [NUM_BANK],
    output logic [DATA_W-1:0]   issue_wdata [NUM_BANK],
    input  logic [NUM_BANK-1:0] issue_ready,
    output logic [NUM_CH-1:0]   alloc,
    output bank_id_t            alloc_bank [NUM_CH]
);

    logic [NUM_BANK-1:0][NUM_CH-1:0] cand;
    logic [NUM_BANK-1:0][NUM_CH-1:0] gnt_oh;
    logic [NUM_CH-1:0][NUM_BANK-1:0] gnt_by_ch;
    ch_id_t                          gnt_ch [NUM_BANK];
    ch_id_t                          rr_ptr [NUM_BANK];    // Highest priority channel.
    logic [NUM_BANK-1:0]             accept;

    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            alloc_bank[c] = ch_req[c].addr[BANK_LSB+1:BANK_LSB];
            for (int b = 0; b < NUM_BANK; b++) begin
                cand[b][c] = ch_req_valid[c] && !rob_full[c] &&
                             (alloc_bank[c] == bank_id_t'(b));
            end
        end
    end

    // Scanning from the far end leaves the candidate nearest the pointer as the winner.
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            issue_valid[b] = 1'b0;
            gnt_ch[b]      = '0;
            for (int k = NUM_CH - 1; k >= 0; k--) begin
                if (cand[b][(int'(rr_ptr[b]) + k) % NUM_CH]) begin
                    issue_valid[b] = 1'b1;
                    gnt_ch[b]      = ch_id_t'((int'(rr_ptr[b]) + k) % NUM_CH);
                end
            end
            accept[b] = issue_valid[b] & issue_ready[b];
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            issue_req[b]   = '0;
            issue_wdata[b] = '0;
            for (int c = 0; c < NUM_CH; c++) begin
                gnt_oh[b][c]    = issue_valid[b] && (gnt_ch[b] == ch_id_t'(c));
                gnt_by_ch[c][b] = gnt_oh[b][c];
                if (gnt_oh[b][c]) begin
                    issue_req[b].addr   = ch_req[c].addr;
                    issue_req[b].ch_id  = ch_id_t'(c);
                    issue_req[b].rob_id = rob_next_id[c];    // Wbuf id is added per bank.
                    issue_wdata[b]      = ch_req[c].wdata;
                end
            end
        end
        for (int c = 0; c < NUM_CH; c++) begin
            ch_req_ready[c] = |(gnt_by_ch[c] & accept);
        end
    end

    assign alloc = ch_req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                rr_ptr[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANK; b++) begin
                if (accept[b]) begin
                    rr_ptr[b] <= (gnt_ch[b] == ch_id_t'(NUM_CH - 1)) ? '0 : gnt_ch[b] + 1'b1;
                end
            end
        end
    end

    // A waiting channel holds its request until the crossbar takes it.
    for (genvar c = 0; c < NUM_CH; c++) begin : g_chk
        a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
            ch_req_valid[c] && !ch_req_ready[c] |=> ch_req_valid[c] && $stable(ch_req[c]))
            else $error("Channel %0d changed its request while waiting", c);
    end

endmodule

/* bank_issue.sv */
`timescale 1ns/10ps

module bank_issue
    import xbar_pkg::*;
#(
    parameter int WBUF_DEPTH = 4
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  bank_req_t         issue_req,
    input  logic [DATA_W-1:0] issue_wdata,
    output logic              issue_ready,
    output logic              bank_req_valid,
    output bank_req_t         bank_req,
    input  logic              bank_req_ready,
    output logic              wbuf_wr_valid,
    output wbuf_wr_t          wbuf_wr,
    input  logic              wbuf_free_valid,
    input  wbuf_id_t          wbuf_free_id
);

    logic [WBUF_DEPTH-1:0] free_map;    // One bit per write-buffer slot, set when free.
    logic [WBUF_DEPTH-1:0] take_oh;
    logic [WBUF_DEPTH-1:0] give_oh;
    wbuf_id_t              take_id;
    logic                  has_free;
    logic                  accept;

    assign take_oh = free_map & (~free_map + 1'b1);    // Lowest free slot.

    always_comb begin
        take_id = '0;
        for (int i = 0; i < WBUF_DEPTH; i++) begin
            if (take_oh[i]) take_id = wbuf_id_t'(i);
            give_oh[i] = wbuf_free_valid && (wbuf_free_id == wbuf_id_t'(i));
        end
    end

    assign has_free       = |free_map;
    assign issue_ready    = bank_req_ready & has_free;
    assign bank_req_valid = issue_valid & has_free;
    assign accept         = issue_valid & issue_ready;
    assign wbuf_wr_valid  = accept;

    always_comb begin
        bank_req         = issue_req;
        bank_req.wbuf_id = take_id;
        wbuf_wr.wbuf_id  = take_id;
        wbuf_wr.wdata    = issue_wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            free_map <= (free_map & ~(accept ? take_oh : '0)) | give_oh;
        end
    end

    // The id must have gone out with an earlier request and not come back yet.
    a_free_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        wbuf_free_valid |-> |(give_oh & ~free_map))
        else $error("Freed wbuf id %0d that is not allocated", wbuf_free_id);

endmodule

/* rsp_xbar.sv */
`timescale 1ns/10ps

module rsp_xbar
    import xbar_pkg::*;
(
    input  logic [NUM_BANK-1:0] bank_rsp_valid,
    input  bank_rsp_t           bank_rsp [NUM_BANK],
    output logic [NUM_BANK-1:0] bank_rsp_ready,
    output logic [NUM_CH-1:0]   fill_valid,
    output rob_id_t             fill_rob_id [NUM_CH],
    output logic [DATA_W-1:0]   fill_data [NUM_CH]
);

    logic [NUM_CH-1:0][NUM_BANK-1:0] hit;
    logic [NUM_CH-1:0][NUM_BANK-1:0] win;
    logic [NUM_BANK-1:0][NUM_CH-1:0] taken;

    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                hit[c][b] = bank_rsp_valid[b] && (bank_rsp[b].ch_id == ch_id_t'(c));
            end
            win[c] = hit[c] & (~hit[c] + 1'b1);    // Lower bank index wins.
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            fill_valid[c]  = |win[c];
            fill_rob_id[c] = '0;
            fill_data[c]   = '0;
            for (int b = 0; b < NUM_BANK; b++) begin
                taken[b][c] = win[c][b];
                if (win[c][b]) begin
                    fill_rob_id[c] = bank_rsp[b].rob_id;
                    fill_data[c]   = bank_rsp[b].rdata;
                end
            end
        end
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_rsp_ready[b] = |taken[b];
            // A response for a missing channel would never be taken.
            if (bank_rsp_valid[b]) begin
                assert (int'(bank_rsp[b].ch_id) < NUM_CH)
                    else $error("Bank %0d response names channel %0d that does not exist",
                                b, bank_rsp[b].ch_id);
            end
        end
    end

endmodule

/* channel_rob.sv */
`timescale 1ns/10ps

module channel_rob
    import xbar_pkg::*;
#(
    parameter int ROB_DEPTH = 8
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc,
    input  bank_id_t            alloc_bank,
    output logic                full,
    output rob_id_t             next_id,
    input  logic                fill_valid,
    input  rob_id_t             fill_rob_id,
    input  logic [DATA_W-1:0]   fill_data,
    output logic                ch_rsp_valid,
    output logic [DATA_W-1:0]   ch_rsp_data,
    input  logic                ch_rsp_ready,
    output logic [NUM_BANK-1:0] retire_oh
);

    localparam int PTR_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    ptr_t                 head;
    ptr_t                 tail;
    logic [PTR_W:0]       count;
    logic [ROB_DEPTH-1:0] busy;      // Allocated and not yet retired.
    logic [ROB_DEPTH-1:0] filled;
    bank_id_t             ent_bank [ROB_DEPTH];
    logic [DATA_W-1:0]    ent_data [ROB_DEPTH];
    ptr_t                 fill_idx;
    logic                 retire;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (int'(count) == ROB_DEPTH);
    assign next_id  = rob_id_t'(tail);    // Ids follow issue order and wrap at the depth.
    assign fill_idx = fill_rob_id[PTR_W-1:0];

    assign ch_rsp_valid = filled[head];
    assign ch_rsp_data  = ent_data[head];
    assign retire       = ch_rsp_valid & ch_rsp_ready;

    always_comb begin
        retire_oh = '0;
        if (retire) retire_oh[ent_bank[head]] = 1'b1;    // Credit goes to the serving bank.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            busy   <= '0;
            filled <= '0;
        end else begin
            if (alloc) begin
                tail       <= ptr_inc(tail);
                busy[tail] <= 1'b1;
            end
            if (fill_valid) filled[fill_idx] <= 1'b1;
            if (retire) begin
                head         <= ptr_inc(head);
                busy[head]   <= 1'b0;
                filled[head] <= 1'b0;
            end
            count <= count + (PTR_W+1)'(alloc) - (PTR_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) ent_bank[tail] <= alloc_bank;
        if (fill_valid) ent_data[fill_idx] <= fill_data;
    end

    // A bank answers only ids that were handed out and answers each one once.
    a_fill_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        fill_valid |-> (int'(fill_rob_id) < ROB_DEPTH) && busy[fill_idx] && !filled[fill_idx])
        else $error("Fill of rob id %0d that is not waiting for data", fill_rob_id);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !full)
        else $error("Alloc while the reorder buffer is full");

endmodule

/* crdt_rtn.sv */
`timescale 1ns/10ps

module crdt_rtn
    import xbar_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_BANK-1:0] retire_oh [NUM_CH],
    output crdt_t               bank_crdt [NUM_BANK]
);

    crdt_t crdt_nxt [NUM_BANK];

    // Each channel retires at most one entry per cycle, so a bank gets up to NUM_CH.
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            crdt_nxt[b] = '0;
            for (int c = 0; c < NUM_CH; c++) begin
                crdt_nxt[b] = crdt_nxt[b] + crdt_t'(retire_oh[c][b]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                bank_crdt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANK; b++) begin
                bank_crdt[b] <= crdt_nxt[b];
            end
        end
    end

endmodule

/* cache_xbar.sv */
`timescale 1ns/10ps

module cache_xbar
    import xbar_pkg::*;
#(
    parameter int ROB_DEPTH  = 8,
    parameter int WBUF_DEPTH = 4
)
(
    input  logic                clk,
    input  logic                rst_n,

    input  logic [NUM_CH-1:0]   ch_req_valid,
    output logic [NUM_CH-1:0]   ch_req_ready,
    input  ch_req_t             ch_req [NUM_CH],
    output logic [NUM_CH-1:0]   ch_rsp_valid,
    input  logic [NUM_CH-1:0]   ch_rsp_ready,
    output logic [DATA_W-1:0]   ch_rsp_data [NUM_CH],

    output logic [NUM_BANK-1:0] bank_req_valid,
    input  logic [NUM_BANK-1:0] bank_req_ready,
    output bank_req_t           bank_req [NUM_BANK],
    output logic [NUM_BANK-1:0] wbuf_wr_valid,
    output wbuf_wr_t            wbuf_wr [NUM_BANK],
    input  logic [NUM_BANK-1:0] wbuf_free_valid,
    input  wbuf_id_t            wbuf_free_id [NUM_BANK],
    input  logic [NUM_BANK-1:0] bank_rsp_valid,
    output logic [NUM_BANK-1:0] bank_rsp_ready,
    input  bank_rsp_t           bank_rsp [NUM_BANK],
    output crdt_t               bank_crdt [NUM_BANK]
);

    logic [NUM_CH-1:0]   rob_full;
    rob_id_t             rob_next_id [NUM_CH];
    logic [NUM_CH-1:0]   alloc;
    bank_id_t            alloc_bank [NUM_CH];
    logic [NUM_BANK-1:0] issue_valid;
    logic [NUM_BANK-1:0] issue_ready;
    bank_req_t           issue_req [NUM_BANK];
    logic [DATA_W-1:0]   issue_wdata [NUM_BANK];
    logic [NUM_CH-1:0]   fill_valid;
    rob_id_t             fill_rob_id [NUM_CH];
    logic [DATA_W-1:0]   fill_data [NUM_CH];
    logic [NUM_BANK-1:0] retire_oh [NUM_CH];

    req_xbar u_req_xbar (.*);

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        bank_issue #(
            .WBUF_DEPTH      (WBUF_DEPTH)
        ) u_bank_issue (
            .clk             (clk),
            .rst_n           (rst_n),
            .issue_valid     (issue_valid[b]),
            .issue_req       (issue_req[b]),
            .issue_wdata     (issue_wdata[b]),
            .issue_ready     (issue_ready[b]),
            .bank_req_valid  (bank_req_valid[b]),
            .bank_req        (bank_req[b]),
            .bank_req_ready  (bank_req_ready[b]),
            .wbuf_wr_valid   (wbuf_wr_valid[b]),
            .wbuf_wr         (wbuf_wr[b]),
            .wbuf_free_valid (wbuf_free_valid[b]),
            .wbuf_free_id    (wbuf_free_id[b])
        );
    end

    rsp_xbar u_rsp_xbar (.*);

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        channel_rob #(
            .ROB_DEPTH    (ROB_DEPTH)
        ) u_channel_rob (
            .clk          (clk),
            .rst_n        (rst_n),
            .alloc        (alloc[c]),
            .alloc_bank   (alloc_bank[c]),
            .full         (rob_full[c]),
            .next_id      (rob_next_id[c]),
            .fill_valid   (fill_valid[c]),
            .fill_rob_id  (fill_rob_id[c]),
            .fill_data    (fill_data[c]),
            .ch_rsp_valid (ch_rsp_valid[c]),
            .ch_rsp_data  (ch_rsp_data[c]),
            .ch_rsp_ready (ch_rsp_ready[c]),
            .retire_oh    (retire_oh[c])
        );
    end

    crdt_rtn u_crdt_rtn (.*);

endmodule

/* tb_cache_xbar.sv */
`timescale 1ns/10ps

module tb_cache_xbar
    import xbar_pkg::*;
();

    localparam int NUM_PAT  = 14;
    localparam int LIMIT    = 200 * NUM_PAT + 500;
    localparam int ROB_LIM  = 8;
    localparam int WBUF_LIM = 4;

    logic                clk = 1'b0;
    logic                rst_n;
    logic [NUM_CH-1:0]   ch_req_valid;
    logic [NUM_CH-1:0]   ch_req_ready;
    ch_req_t             ch_req [NUM_CH];
    logic [NUM_CH-1:0]   ch_rsp_valid;
    logic [NUM_CH-1:0]   ch_rsp_ready;
    logic [DATA_W-1:0]   ch_rsp_data [NUM_CH];
    logic [NUM_BANK-1:0] bank_req_valid;
    logic [NUM_BANK-1:0] bank_req_ready;
    bank_req_t           bank_req [NUM_BANK];
    logic [NUM_BANK-1:0] wbuf_wr_valid;
    wbuf_wr_t            wbuf_wr [NUM_BANK];
    logic [NUM_BANK-1:0] wbuf_free_valid;
    wbuf_id_t            wbuf_free_id [NUM_BANK];
    logic [NUM_BANK-1:0] bank_rsp_valid;
    logic [NUM_BANK-1:0] bank_rsp_ready;
    bank_rsp_t           bank_rsp [NUM_BANK];
    crdt_t               bank_crdt [NUM_BANK];

    logic [DATA_W-1:0]   pat_mem [3*NUM_PAT];
    logic [31:0]         seed = 32'hf6e785fb;
    int                  cycle_cnt = 0;
    int                  err_cnt = 0;
    logic                hold = 1'b0;    // The bank model withholds its responses.
    ch_req_t             req_q [NUM_CH][$];
    ch_req_t             exp_q [NUM_CH][$];    // Accepted and not yet retired.
    bank_rsp_t           pend_rsp [NUM_BANK][$];
    wbuf_id_t            pend_wid [NUM_BANK][$];
    int                  pend_due [NUM_BANK][$];
    logic [NUM_BANK-1:0] free_pend = '0;
    wbuf_id_t            free_id_pend [NUM_BANK];
    logic [WBUF_MAX-1:0] wbuf_busy [NUM_BANK];
    int                  retire_cnt [NUM_BANK];
    int                  crdt_sum [NUM_BANK];
    logic [NUM_CH-1:0]   stall = '0;
    logic [DATA_W-1:0]   stall_data [NUM_CH];

    cache_xbar #(
        .ROB_DEPTH  (ROB_LIM),
        .WBUF_DEPTH (WBUF_LIM)
    ) uut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // A bank answers with the line address repeated across the data XOR the write data.
    function automatic logic [DATA_W-1:0] line_data(logic [ADDR_W-1:0] addr,
                                                    logic [DATA_W-1:0] wdata);
        return {4{addr}} ^ wdata;
    endfunction

    function automatic bit traffic_pending();
        bit any;
        any = 1'b0;
        for (int i = 0; i < NUM_CH; i++) any |= (req_q[i].size() > 0) || (exp_q[i].size() > 0);
        for (int i = 0; i < NUM_BANK; i++) any |= (pend_rsp[i].size() > 0);
        return any;
    endfunction

    task automatic flag_mismatch(string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic flag_error(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        for (int c = 0; c < NUM_CH; c++) begin
            ch_req_valid[c] = (req_q[c].size() > 0);
            ch_req[c]       = '0;
            if (req_q[c].size() > 0) ch_req[c] = req_q[c][0];
            r = next_rand();
            ch_rsp_ready[c] = (r[31:30] != 2'b00);
        end
        for (int b = 0; b < NUM_BANK; b++) begin
            r = next_rand();
            bank_req_ready[b] = (r[31:30] != 2'b00);
            bank_rsp_valid[b] = 1'b0;
            bank_rsp[b]       = '0;
            if (!hold && pend_rsp[b].size() > 0 && pend_due[b][0] <= cycle_cnt) begin
                bank_rsp_valid[b] = 1'b1;
                bank_rsp[b]       = pend_rsp[b][0];
            end
            wbuf_free_valid[b] = free_pend[b];    // Freed once the response has gone out.
            wbuf_free_id[b]    = free_id_pend[b];
            free_pend[b]       = 1'b0;
        end
    endtask

    task automatic observe();
        int bk;
        int ch;
        logic [31:0] r;
        logic exp_rdy;
        bank_rsp_t rsp;
        for (int c = 0; c < NUM_CH; c++) begin
            if (stall[c]) assert (ch_rsp_valid[c] && ch_rsp_data[c] == stall_data[c])
                else flag_error($sformatf("channel %0d response moved while stalled", c));
            stall[c]      = ch_rsp_valid[c] && !ch_rsp_ready[c];
            stall_data[c] = ch_rsp_data[c];
            if (ch_rsp_valid[c] && ch_rsp_ready[c]) begin
                assert (exp_q[c].size() > 0)
                    else flag_error($sformatf("channel %0d response with nothing in flight", c));
                if (exp_q[c].size() > 0) begin
                    assert (ch_rsp_data[c] == line_data(exp_q[c][0].addr, exp_q[c][0].wdata))
                        else flag_mismatch($sformatf("channel %0d response data", c));
                    retire_cnt[int'(exp_q[c][0].addr[BANK_LSB+1:BANK_LSB])]++;
                    void'(exp_q[c].pop_front());
                end
            end
            if (ch_req_valid[c] && ch_req_ready[c]) begin
                bk = int'(ch_req[c].addr[BANK_LSB+1:BANK_LSB]);
                assert (bank_req_valid[bk] && bank_req_ready[bk] &&
                        bank_req[bk].ch_id == ch_id_t'(c) && bank_req[bk].addr == ch_req[c].addr)
                    else flag_mismatch($sformatf("channel %0d request not at bank %0d", c, bk));
                assert (wbuf_wr_valid[bk] && wbuf_wr[bk].wbuf_id == bank_req[bk].wbuf_id &&
                        wbuf_wr[bk].wdata == ch_req[c].wdata)
                    else flag_mismatch($sformatf("channel %0d write buffer data", c));
                exp_q[c].push_back(ch_req[c]);
                void'(req_q[c].pop_front());
            end
            assert (exp_q[c].size() <= ROB_LIM)
                else flag_error($sformatf("channel %0d has too many requests in flight", c));
        end
        for (int b = 0; b < NUM_BANK; b++) begin
            assert ($countones(wbuf_busy[b]) <= WBUF_LIM)
                else flag_error($sformatf("bank %0d holds too many write buffer ids", b));
            if ($countones(wbuf_busy[b]) == WBUF_LIM && bank_req_ready[b])
                assert (!bank_req_valid[b])
                    else flag_error($sformatf("bank %0d issued with no free write buffer", b));
            if (bank_req_valid[b] && bank_req_ready[b]) begin
                ch = int'(bank_req[b].ch_id);
                assert (bank_req[b].addr[BANK_LSB+1:BANK_LSB] == bank_id_t'(b) &&
                        ch < NUM_CH && ch_req_valid[ch] && ch_req_ready[ch])
                    else flag_error($sformatf("bank %0d took a request no channel sent", b));
                assert (!wbuf_busy[b][bank_req[b].wbuf_id] && bank_req[b].wbuf_id < WBUF_LIM)
                    else flag_error($sformatf("bank %0d reused a busy write buffer id", b));
                wbuf_busy[b][bank_req[b].wbuf_id] = 1'b1;
                rsp.rdata  = line_data(bank_req[b].addr, wbuf_wr[b].wdata);
                rsp.ch_id  = bank_req[b].ch_id;
                rsp.rob_id = bank_req[b].rob_id;
                r = next_rand();
                pend_rsp[b].push_back(rsp);
                pend_wid[b].push_back(bank_req[b].wbuf_id);
                pend_due[b].push_back(cycle_cnt + 1 + int'(r[31:16] % 16'd6));
            end
            if (wbuf_free_valid[b]) wbuf_busy[b][wbuf_free_id[b]] = 1'b0;
            // A lower bank answering the same channel takes the response path first.
            exp_rdy = bank_rsp_valid[b] && (int'(bank_rsp[b].ch_id) < NUM_CH);
            for (int l = 0; l < b; l++) begin
                if (bank_rsp_valid[l] && bank_rsp[l].ch_id == bank_rsp[b].ch_id) exp_rdy = 1'b0;
            end
            assert (bank_rsp_ready[b] == exp_rdy)
                else flag_mismatch($sformatf("bank %0d response ready", b));
            if (bank_rsp_valid[b] && bank_rsp_ready[b]) begin
                free_pend[b]    = 1'b1;
                free_id_pend[b] = pend_wid[b][0];
                void'(pend_rsp[b].pop_front());
                void'(pend_wid[b].pop_front());
                void'(pend_due[b].pop_front());
            end
            crdt_sum[b] += int'(bank_crdt[b]);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        drive_inputs();
        @(negedge clk);
        observe();
        cycle_cnt++;
    endtask

    initial begin
        int total;
        rst_n           = 1'b0;
        ch_req_valid    = '0;
        ch_rsp_ready    = '0;
        bank_req_ready  = '0;
        wbuf_free_valid = '0;
        bank_rsp_valid  = '0;
        for (int c = 0; c < NUM_CH; c++) ch_req[c] = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_rsp[b]     = '0;
            wbuf_free_id[b] = '0;
            free_id_pend[b] = '0;
            wbuf_busy[b]    = '0;
            retire_cnt[b]   = 0;
            crdt_sum[b]     = 0;
        end
        $readmemh("xbar_patterns.txt", pat_mem);
        for (int i = 0; i < NUM_PAT; i++) begin
            req_q[int'(pat_mem[3*i])].push_back({pat_mem[3*i+1][ADDR_W-1:0], pat_mem[3*i+2]});
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (traffic_pending()) step();

        // Channel 0 fills its reorder buffer, two requests per bank, then channel 1 fills bank 0.
        hold = 1'b1;
        for (int i = 0; i < 10; i++) req_q[0].push_back({32'h8000 + i * 64, {4{next_rand()}}});
        while (exp_q[0].size() < ROB_LIM) step();
        repeat (20) step();
        assert (exp_q[0].size() == ROB_LIM && req_q[0].size() == 2)
            else flag_mismatch($sformatf("channel 0 holds %0d in flight", exp_q[0].size()));
        for (int i = 0; i < 3; i++) req_q[1].push_back({32'h3000 + i * 256, {4{next_rand()}}});
        while ($countones(wbuf_busy[0]) < WBUF_LIM) step();
        repeat (20) step();
        assert (req_q[1].size() == 1)
            else flag_error("bank 0 accepted a request with all write buffer ids in use");
        hold = 1'b0;
        while (traffic_pending()) step();
        repeat (4) step();

        total = 0;
        for (int b = 0; b < NUM_BANK; b++) begin
            assert (crdt_sum[b] == retire_cnt[b])
                else flag_mismatch($sformatf("bank %0d credits %0d, retirements %0d",
                                             b, crdt_sum[b], retire_cnt[b]));
            total += retire_cnt[b];
        end
        $display("Errors: %0d, retirements: %0d, cycles: %0d", err_cnt, total, cycle_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (cycle_cnt > LIMIT) begin
            $display("Timeout after %0d cycles with traffic still pending", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* xbar_patterns.txt */
// One request per line, read three hex words at a time.
// Columns: channel, address (bank is bits 7:6), write data.
0 00001000 0123456789abcdef0011223344556677
1 00001040 fedcba987654321000ffeeddccbbaa99
2 00001080 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
0 000010c0 00000001000000020000000300000004
1 00002000 deadbeefcafef00d1234567889abcdef
2 00002100 1111111122222222333333334444444
0 00002140 abcdef0123456789abcdef0123456789
1 000031c0 8000000000000000000000000000001
2 00003040 13579bdf02468ace13579bdf02468ace
0 00004080 ffffffff00000000ffffffff00000000
1 00004000 0badc0de0badc0de0badc0de0badc0de
2 000050c0 5555aaaa5555aaaa5555aaaa5555aaaa
0 00005000 76543210fedcba9876543210fedcba98
1 00006180 c3c3c3c33c3c3c3c96969696e1e1e1e1

/* files.f */
xbar_pkg.sv
req_xbar.sv
bank_issue.sv
rsp_xbar.sv
channel_rob.sv
crdt_rtn.sv
cache_xbar.sv
tb_cache_xbar.sv

/* Makefile */
# Verilator build and run of the cache crossbar testbench.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if sim.log holds the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module tb_cache_xbar -Mdir obj_dir -f files.f
	./obj_dir/Vtb_cache_xbar | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
